// ==== src/lg_defs.svh ====
//////////////////////////////
// waveform generator widths, register map
// and unity gain constant
//////////////////////////////
`ifndef LG_DEFS_SVH
`define LG_DEFS_SVH

`define LG_DW      14               // sample width
`define LG_CWM     10               // table address bits
`define LG_CWF     16               // pointer fraction bits
`define LG_CWL     32               // burst length counter
`define LG_CWN     16               // burst number counter
`define LG_TN      4                // external triggers
`define LG_MUL_ONE (16'h1 << 14)    // gain 1.0 in 2.14

// register offsets, low 6 address bits
`define LG_A_CTL   6'h00
`define LG_A_TRG   6'h04
`define LG_A_SIZ   6'h10
`define LG_A_OFF   6'h14
`define LG_A_STP   6'h18
`define LG_A_BCF   6'h20
`define LG_A_BDL   6'h24
`define LG_A_BLN   6'h28
`define LG_A_BNM   6'h2c
`define LG_A_SBL   6'h30
`define LG_A_SBN   6'h34
`define LG_A_MUL   6'h38
`define LG_A_SUM   6'h3c

`endif

// ==== src/lg_pkg.sv ====
//////////////////////////////
// shared types of the waveform
// generator
//////////////////////////////
`include "lg_defs.svh"
`default_nettype none

package lg_pkg;

  typedef logic signed [`LG_DW-1:0]         sample_t;  // dac sample
  typedef logic [`LG_CWM+`LG_CWF-1:0]       ptr_t;     // int.frac table pointer
  typedef logic signed [15:0]               gain_t;    // 2.14 gain
  typedef logic [`LG_TN-1:0]                trg_t;     // trigger vector

endpackage

`default_nettype wire

// ==== src/lg_regs.sv ====
//////////////////////////////
// bus register file: config, control
// pulses, status readback and routing
// of accesses into the waveform table
//////////////////////////////
`timescale 1ns/1ps
`include "lg_defs.svh"
`default_nettype none

module lg_regs (
  input  logic                bus,
  input  logic                rst_n,
  input  logic [31:0]         addr,
  input  logic [31:0]         wdata,
  input  logic                wen,
  input  logic                ren,
  output logic [31:0]         rdata,
  output logic                ack,
  // table port
  output logic                buf_wen,
  output logic                buf_ren,
  output logic [`LG_CWM-1:0]  buf_addr,
  output lg_pkg::sample_t     buf_wdata,
  input  lg_pkg::sample_t     buf_rdata,
  // control
  output logic                ctl_rst,
  output logic                trg_swo,
  // config
  output lg_pkg::trg_t        cfg_trg,
  output lg_pkg::ptr_t        cfg_siz,
  output lg_pkg::ptr_t        cfg_off,
  output lg_pkg::ptr_t        cfg_stp,
  output logic                cfg_ben,
  output logic                cfg_inf,
  output logic [`LG_CWM-1:0]  cfg_bdl,
  output logic [`LG_CWL-1:0]  cfg_bln,
  output logic [`LG_CWN-1:0]  cfg_bnm,
  output lg_pkg::gain_t       cfg_mul,
  output lg_pkg::sample_t     cfg_sum,
  // status
  input  logic                sts_run,
  input  logic [`LG_CWL-1:0]  sts_bln,
  input  logic [`LG_CWN-1:0]  sts_bnm
);

  localparam int PW = `LG_CWM + `LG_CWF;  // pointer width

  logic        buf_sel;    // table window hit
  logic        reg_wen;    // register write
  logic [5:0]  reg_adr;
  logic        buf_ack;    // pending ack is a table read
  logic [31:0] reg_rdata;

  assign buf_sel = addr[`LG_CWM+2];
  assign reg_adr = addr[5:0];
  assign reg_wen = wen & ~buf_sel;

  // table steering, word addressed
  assign buf_wen   = wen & buf_sel;
  assign buf_ren   = ren & buf_sel;
  assign buf_addr  = addr[`LG_CWM+1:2];
  assign buf_wdata = wdata[`LG_DW-1:0];

  // strobes live only in the write cycle
  assign ctl_rst = reg_wen & (reg_adr == `LG_A_CTL) & wdata[0];
  assign trg_swo = reg_wen & (reg_adr == `LG_A_CTL) & wdata[1];

  //////////////////////////////
  // config registers
  //////////////////////////////
  always_ff @(posedge bus or negedge rst_n) begin
    if (!rst_n) begin
      cfg_trg <= '0;
      cfg_siz <= '0;
      cfg_off <= '0;
      cfg_stp <= '0;
      cfg_ben <= 1'b0;
      cfg_inf <= 1'b0;
      cfg_bdl <= '0;
      cfg_bln <= '0;
      cfg_bnm <= '0;
      cfg_mul <= `LG_MUL_ONE;  // unity gain
      cfg_sum <= '0;
    end else if (reg_wen) begin
      case (reg_adr)
        `LG_A_TRG: cfg_trg <= wdata[`LG_TN-1:0];
        `LG_A_SIZ: cfg_siz <= wdata[PW-1:0];
        `LG_A_OFF: cfg_off <= wdata[PW-1:0];
        `LG_A_STP: cfg_stp <= wdata[PW-1:0];
        `LG_A_BCF: begin
          cfg_ben <= wdata[0];
          cfg_inf <= wdata[1];
        end
        `LG_A_BDL: cfg_bdl <= wdata[`LG_CWM-1:0];
        `LG_A_BLN: cfg_bln <= wdata[`LG_CWL-1:0];
        `LG_A_BNM: cfg_bnm <= wdata[`LG_CWN-1:0];
        `LG_A_MUL: cfg_mul <= wdata[15:0];
        `LG_A_SUM: cfg_sum <= wdata[`LG_DW-1:0];
        default: ;               // ctl and status are not stored
      endcase
    end
  end

  //////////////////////////////
  // readback
  //////////////////////////////
  always_ff @(posedge bus) begin
    if (ren) begin
      case (reg_adr)
        `LG_A_CTL: reg_rdata <= {28'h0, ~sts_run, sts_run, 2'b00};
        `LG_A_TRG: reg_rdata <= 32'(cfg_trg);
        `LG_A_SIZ: reg_rdata <= 32'(cfg_siz);
        `LG_A_OFF: reg_rdata <= 32'(cfg_off);
        `LG_A_STP: reg_rdata <= 32'(cfg_stp);
        `LG_A_BCF: reg_rdata <= {30'h0, cfg_inf, cfg_ben};
        `LG_A_BDL: reg_rdata <= 32'(cfg_bdl);
        `LG_A_BLN: reg_rdata <= 32'(cfg_bln);
        `LG_A_BNM: reg_rdata <= 32'(cfg_bnm);
        `LG_A_SBL: reg_rdata <= 32'(sts_bln);
        `LG_A_SBN: reg_rdata <= 32'(sts_bnm);
        `LG_A_MUL: reg_rdata <= 32'($unsigned(cfg_mul));  // field only
        `LG_A_SUM: reg_rdata <= 32'($unsigned(cfg_sum));
        default:   reg_rdata <= '0;   // unmapped
      endcase
    end
  end

  always_ff @(posedge bus or negedge rst_n) begin
    if (!rst_n) begin
      ack     <= 1'b0;
      buf_ack <= 1'b0;
    end else begin
      ack     <= wen | ren;           // one cycle, table and regs alike
      buf_ack <= ren & buf_sel;
    end
  end

  // table data arrives in the ack cycle, sign extended
  assign rdata = buf_ack ? 32'(buf_rdata) : reg_rdata;

  // single-cycle strobes must give single-cycle acks
  a_ack_pulse: assert property (@(posedge bus) disable iff (!rst_n) ack |=> !ack);

endmodule

`default_nettype wire

// ==== src/lg_buf.sv ====
//////////////////////////////
// dual port waveform table
// bus r/w port, engine read port
//////////////////////////////
`timescale 1ns/1ps
`include "lg_defs.svh"
`default_nettype none

module lg_buf (
  input  logic                bus,
  // bus side
  input  logic                buf_wen,
  input  logic                buf_ren,
  input  logic [`LG_CWM-1:0]  buf_addr,
  input  lg_pkg::sample_t     buf_wdata,
  output lg_pkg::sample_t     buf_rdata,
  // engine side
  input  logic [`LG_CWM-1:0]  rd_addr,
  output lg_pkg::sample_t     rd_data
);
  import lg_pkg::*;

  sample_t mem [0:2**`LG_CWM-1];

  // bus port, write and read share the address
  always_ff @(posedge bus) begin
    if (buf_wen) begin
      mem[buf_addr] <= buf_wdata;
    end
    if (buf_ren) begin
      buf_rdata <= mem[buf_addr];  // valid in the ack cycle
    end
  end

  // engine port reads every cycle, a held address re-reads
  always_ff @(posedge bus) begin
    rd_data <= mem[rd_addr];
  end

endmodule

`default_nettype wire

// ==== src/lg_asg.sv ====
//////////////////////////////
// playback engine: trigger, fixed
// point table pointer with wrap,
// burst counters and sample output
//////////////////////////////
`timescale 1ns/1ps
`include "lg_defs.svh"
`default_nettype none

module lg_asg (
  input  logic                bus,
  input  logic                rst_n,
  input  lg_pkg::trg_t        trg_ext,
  input  logic                trg_swo,
  input  logic                ctl_rst,
  input  lg_pkg::trg_t        cfg_trg,
  input  lg_pkg::ptr_t        cfg_siz,
  input  lg_pkg::ptr_t        cfg_off,
  input  lg_pkg::ptr_t        cfg_stp,
  input  logic                cfg_ben,
  input  logic                cfg_inf,
  input  logic [`LG_CWM-1:0]  cfg_bdl,
  input  logic [`LG_CWL-1:0]  cfg_bln,
  input  logic [`LG_CWN-1:0]  cfg_bnm,
  output logic [`LG_CWM-1:0]  rd_addr,
  input  lg_pkg::sample_t     rd_data,
  output logic                stg_valid,
  output lg_pkg::sample_t     stg_data,
  input  logic                stg_ready,
  output logic                trg_out,
  output logic                irq_trg,
  output logic                irq_stp,
  output logic                sts_run,
  output logic [`LG_CWL-1:0]  sts_bln,
  output logic [`LG_CWN-1:0]  sts_bnm
);
  import lg_pkg::*;

  localparam int PW = `LG_CWM + `LG_CWF;

  typedef enum logic [1:0] {ST_IDLE, ST_DATA, ST_PAUSE} state_t;

  state_t              state;
  trg_t                trg_q;       // for edge detect
  logic                start;
  ptr_t                ptr;
  logic [PW:0]         ptr_sum;     // one spare bit for the carry
  logic [PW:0]         ptr_wrp;
  logic [`LG_CWL-1:0]  bln_nxt;
  logic [`LG_CWN-1:0]  bnm_nxt;
  logic                phs_end;     // last sample of data or pause
  logic                bnm_last;
  logic                adv;         // issue one sample slot
  logic                rd_req;      // slot reads the table
  logic [`LG_CWM-1:0]  ra;          // address of the read in flight
  logic                rd_vld;      // rd_data holds a pending sample
  logic                rd_zro;      // pending sample is pause
  logic                ld;          // pending sample moves to output

  //////////////////////////////
  // trigger
  //////////////////////////////
  always_ff @(posedge bus or negedge rst_n) begin
    if (!rst_n) begin
      trg_q <= '0;
    end else begin
      trg_q <= trg_ext;
    end
  end

  // sw pulse or masked rising edge, ignored while running
  assign start = (trg_swo | (|(trg_ext & ~trg_q & cfg_trg))) & (state == ST_IDLE) & ~ctl_rst;

  //////////////////////////////
  // pointer and counters
  //////////////////////////////
  assign ptr_sum  = {1'b0, ptr} + {1'b0, cfg_stp};
  assign ptr_wrp  = (ptr_sum >= {1'b0, cfg_siz}) ? ptr_sum - {1'b0, cfg_siz} : ptr_sum;
  assign bln_nxt  = sts_bln + 1'b1;
  assign bnm_nxt  = sts_bnm + 1'b1;
  assign bnm_last = ~cfg_inf & (bnm_nxt == cfg_bnm);
  assign phs_end  = (state == ST_DATA) ? cfg_ben & (bln_nxt == `LG_CWL'(cfg_bdl))
                                       : (bln_nxt == cfg_bln);

  assign ld     = rd_vld & (~stg_valid | stg_ready);
  assign adv    = (state != ST_IDLE) & (~rd_vld | ld);  // room once the pending one moves
  assign rd_req = adv & (state == ST_DATA);
  assign rd_addr = rd_req ? ptr[PW-1:`LG_CWF] : ra;
  assign sts_run = state != ST_IDLE;

  always_ff @(posedge bus or negedge rst_n) begin
    if (!rst_n) begin
      state   <= ST_IDLE;
      ptr     <= '0;
      sts_bln <= '0;
      sts_bnm <= '0;
      trg_out <= 1'b0;
      irq_trg <= 1'b0;
      irq_stp <= 1'b0;
    end else begin
      trg_out <= start;
      irq_trg <= start;
      irq_stp <= 1'b0;
      if (ctl_rst) begin
        state   <= ST_IDLE;
        sts_bln <= '0;
        sts_bnm <= '0;
      end else if (start) begin
        state   <= ST_DATA;
        ptr     <= cfg_off;
        sts_bln <= '0;
        sts_bnm <= '0;
      end else if (adv) begin
        sts_bln <= bln_nxt;
        if (state == ST_DATA) begin
          ptr <= ptr_wrp[PW-1:0];
        end
        if (phs_end) begin
          if (state == ST_DATA && cfg_bln != '0) begin
            state   <= ST_PAUSE;   // zeros follow
            sts_bln <= '0;
          end else if (bnm_last) begin
            state   <= ST_IDLE;    // final counts stay visible
            sts_bnm <= bnm_nxt;
            irq_stp <= 1'b1;
          end else begin
            state   <= ST_DATA;    // next burst from the offset
            ptr     <= cfg_off;
            sts_bln <= '0;
            sts_bnm <= bnm_nxt;
          end
        end
      end
    end
  end

  //////////////////////////////
  // output register
  //////////////////////////////
  always_ff @(posedge bus or negedge rst_n) begin
    if (!rst_n) begin
      rd_vld    <= 1'b0;
      stg_valid <= 1'b0;
    end else begin
      rd_vld <= ~ctl_rst & (adv | (rd_vld & ~ld));  // drop the pending read on reset
      if (ld) begin
        stg_valid <= 1'b1;
      end else if (stg_ready) begin
        stg_valid <= 1'b0;
      end
    end
  end

  always_ff @(posedge bus) begin
    ra <= rd_addr;
    if (adv) begin
      rd_zro <= state == ST_PAUSE;
    end
    if (ld) begin
      stg_data <= rd_zro ? '0 : rd_data;
    end
  end

  a_stg_hold: assert property (@(posedge bus) disable iff (!rst_n)
    stg_valid && !stg_ready |=> stg_valid && $stable(stg_data));

  // table reads stay inside the configured size
  a_rd_range: assert property (@(posedge bus) disable iff (!rst_n)
    rd_req |-> rd_addr < cfg_siz[PW-1:`LG_CWF]);

endmodule

`default_nettype wire

// ==== src/lg_lin.sv ====
//////////////////////////////
// gain and offset stage, two
// registers, saturating output
//////////////////////////////
`timescale 1ns/1ps
`include "lg_defs.svh"
`default_nettype none

module lg_lin (
  input  logic              bus,
  input  logic              rst_n,
  input  logic              stg_valid,
  input  lg_pkg::sample_t   stg_data,
  output logic              stg_ready,
  input  lg_pkg::gain_t     cfg_mul,
  input  lg_pkg::sample_t   cfg_sum,
  output logic              sto_valid,
  output lg_pkg::sample_t   sto_data,
  input  logic              sto_ready
);
  import lg_pkg::*;

  logic signed [`LG_DW+15:0]  mul_p;   // full product
  logic signed [15:0]         s1_dat;  // product >>> 14
  logic                       s1_vld;
  logic                       s1_en;
  logic                       s2_en;
  logic signed [16:0]         add_s;
  logic                       add_ok;  // fits the sample range
  sample_t                    add_sat;

  // a stage moves when its successor is empty or draining
  assign s2_en     = ~sto_valid | sto_ready;
  assign s1_en     = ~s1_vld | s2_en;
  assign stg_ready = s1_en;

  assign mul_p = stg_data * cfg_mul;

  assign add_s   = 17'(s1_dat) + 17'(cfg_sum);
  assign add_ok  = (&add_s[16:`LG_DW-1]) | ~(|add_s[16:`LG_DW-1]);
  assign add_sat = add_ok ? add_s[`LG_DW-1:0] : {add_s[16], {(`LG_DW-1){~add_s[16]}}};

  always_ff @(posedge bus or negedge rst_n) begin
    if (!rst_n) begin
      s1_vld    <= 1'b0;
      sto_valid <= 1'b0;
    end else begin
      if (s1_en) s1_vld    <= stg_valid;
      if (s2_en) sto_valid <= s1_vld;
    end
  end

  // data path
  always_ff @(posedge bus) begin
    if (s1_en && stg_valid) begin
      s1_dat <= mul_p[`LG_DW+15:14];  // arithmetic shift by 14
    end
    if (s2_en && s1_vld) begin
      sto_data <= add_sat;
    end
  end

  a_sto_hold: assert property (@(posedge bus) disable iff (!rst_n)
    sto_valid && !sto_ready |=> $stable(sto_data));

endmodule

`default_nettype wire

// ==== src/lg_top.sv ====
//////////////////////////////
// waveform generator top: regs,
// table, engine and gain stage
//////////////////////////////
`timescale 1ns/1ps
`include "lg_defs.svh"
`default_nettype none

module lg_top (
  input  logic              bus,
  input  logic              rst_n,
  input  logic [31:0]       addr,
  input  logic [31:0]       wdata,
  input  logic              wen,
  input  logic              ren,
  output logic [31:0]       rdata,
  output logic              ack,
  input  lg_pkg::trg_t      trg_ext,
  output logic              trg_swo,
  output logic              trg_out,
  output logic              irq_trg,
  output logic              irq_stp,
  output logic              sto_valid,
  output lg_pkg::sample_t   sto_data,
  input  logic              sto_ready
);
  import lg_pkg::*;

  // table access from the bus
  logic                buf_wen;
  logic                buf_ren;
  logic [`LG_CWM-1:0]  buf_addr;
  sample_t             buf_wdata;
  sample_t             buf_rdata;
  // control and config
  logic                ctl_rst;
  trg_t                cfg_trg;
  ptr_t                cfg_siz;
  ptr_t                cfg_off;
  ptr_t                cfg_stp;
  logic                cfg_ben;
  logic                cfg_inf;
  logic [`LG_CWM-1:0]  cfg_bdl;
  logic [`LG_CWL-1:0]  cfg_bln;
  logic [`LG_CWN-1:0]  cfg_bnm;
  gain_t               cfg_mul;
  sample_t             cfg_sum;
  // status
  logic                sts_run;
  logic [`LG_CWL-1:0]  sts_bln;
  logic [`LG_CWN-1:0]  sts_bnm;
  // engine table port and stream
  logic [`LG_CWM-1:0]  rd_addr;
  sample_t             rd_data;
  logic                stg_valid;
  sample_t             stg_data;
  logic                stg_ready;

  // all nets share port names
  lg_regs i_lg_regs (.*);
  lg_buf  i_lg_buf  (.*);
  lg_asg  i_lg_asg  (.*);
  lg_lin  i_lg_lin  (.*);

endmodule

`default_nettype wire

// ==== test/lg_tb.sv ====
//////////////////////////////
// trace driven testbench for the
// waveform generator top level
//////////////////////////////
`timescale 1ns/1ps
`include "lg_defs.svh"
`default_nettype none

module lg_tb;
  import lg_pkg::*;

  localparam string TRACE = "test/lg_trace.txt";

  logic         bus;
  logic         rst_n;
  logic [31:0]  addr;
  logic [31:0]  wdata;
  logic         wen;
  logic         ren;
  logic [31:0]  rdata;
  logic         ack;
  trg_t         trg_ext;
  logic         trg_swo;
  logic         trg_out;
  logic         irq_trg;
  logic         irq_stp;
  logic         sto_valid;
  sample_t      sto_data;
  logic         sto_ready;

  sample_t      got_q [$];   // accepted output samples, in order
  logic         irq_seen;    // sticky stop interrupt
  int           swo_cnt;
  int           out_cnt;
  int           irq_cnt;     // start interrupt pulses
  logic         bp_on;       // random back-pressure
  int           cycles;
  int           limit = 0;
  int           errors;
  int           checks;
  int           tests;

  lg_top i_lg_top (.*);

  initial begin
    bus = 1'b0;
    forever #10 bus = ~bus;  // 20 ns
  end

  //////////////////////////////
  // stream monitor, pulse counters
  //////////////////////////////
  always @(posedge bus) begin
    if (rst_n && sto_valid && sto_ready) got_q.push_back(sto_data);
    if (irq_stp) irq_seen = 1'b1;
    if (trg_swo) swo_cnt++;
    if (trg_out) out_cnt++;
    if (irq_trg) irq_cnt++;
  end

  initial begin
    void'($urandom(32'ha3cb798f));  // one seed for the stall pattern
    forever begin
      @(posedge bus);
      #2;
      sto_ready = bp_on ? (($urandom % 3) != 0) : 1'b1;  // stall about a third
    end
  end

  initial begin
    cycles = 0;
    wait (limit > 0);
    while (cycles < limit) begin
      @(posedge bus);
      cycles++;
    end
    $display("timeout: run went past %0d cycles", limit);
    $display("Verification failed");
    $finish;
  end

  //////////////////////////////
  // helpers
  //////////////////////////////
  task automatic check_value(input string name, input logic [31:0] exp,
                             input logic [31:0] got);
    checks++;
    assert (got === exp) else begin
      $display("** Error at %0t ns: %s expected %h got %h", $time, name, exp, got);
      errors++;
    end
  endtask

  // one strobe cycle, ack one cycle later
  task automatic bus_access(input logic write, input logic [31:0] a, input logic [31:0] d,
                            output logic [31:0] q);
    int n;
    n = 0;
    @(posedge bus);
    #2;
    addr  = a;
    wdata = d;
    wen   = write;
    ren   = ~write;
    @(posedge bus);
    #2;
    wen = 1'b0;
    ren = 1'b0;
    while (!ack && n < 16) begin
      @(posedge bus);
      #2;
      n++;
    end
    q = rdata;                 // stable in the ack cycle
    assert (ack) else begin
      $display("no bus ack for the access to address %h", a);
      errors++;
    end
  endtask

  task automatic pulse_trigger(input trg_t m);
    @(posedge bus);
    #2;
    trg_ext = m;
    @(posedge bus);
    @(posedge bus);
    #2;
    trg_ext = '0;
  endtask

  task automatic collect_stream(input int fd, input int n);
    logic [31:0] v;
    logic [31:0] smask;
    sample_t     s;
    int          code;
    int          k;
    int          w;
    smask = (32'h1 << `LG_DW) - 1;
    for (k = 0; k < n; k++) begin
      code = $fscanf(fd, "%h", v);
      w = 0;
      while (got_q.size() == 0 && w < 500) begin
        @(posedge bus);
        #1;
        w++;
      end
      assert (got_q.size() > 0) else begin
        $display("stream sample %0d of %0d never arrived", k + 1, n);
        errors++;
      end
      if (got_q.size() > 0) begin
        s = got_q.pop_front();
        check_value("sto_data", v & smask, 32'($unsigned(s)));
      end
    end
  endtask

  task automatic wait_stop();
    int n;
    n = 0;
    while (!irq_seen && n < 1000) begin
      @(posedge bus);
      #1;
      n++;
    end
    checks++;
    assert (irq_seen) else begin
      $display("irq_stp never pulsed within %0d cycles", n);
      errors++;
    end
    irq_seen = 1'b0;
  endtask

  task automatic skip_line(input int fd);
    int c;
    c = 0;
    while (c != 10 && c != -1) begin
      c = $fgetc(fd);
    end
  endtask

  task automatic end_test(input logic [8*32-1:0] name, input int base);
    if (name != '0) begin
      if (errors == base) $display("test %0s: ok", name);
      else $display("test %0s: %0d errors", name, errors - base);
    end
  endtask

  //////////////////////////////
  // trace runner
  //////////////////////////////
  initial begin
    int               fd;
    int               code;
    int               c;
    int               nlines;
    int               base;
    int               n;
    int               m;
    logic [7:0]       cmd;
    logic [31:0]      a;
    logic [31:0]      d;
    logic [31:0]      q;
    logic [8*32-1:0]  name;
    logic             done;
    rst_n     = 1'b0;
    addr      = '0;
    wdata     = '0;
    wen       = 1'b0;
    ren       = 1'b0;
    trg_ext   = '0;
    sto_ready = 1'b1;
    bp_on     = 1'b0;
    irq_seen  = 1'b0;
    swo_cnt   = 0;
    out_cnt   = 0;
    irq_cnt   = 0;
    errors    = 0;
    checks    = 0;
    tests     = 0;
    nlines    = 0;
    name      = '0;
    base      = 0;
    fd = $fopen(TRACE, "r");
    if (fd != 0) begin
      c = 0;
      while (c != -1) begin    // first pass sizes the timeout
        c = $fgetc(fd);
        if (c == 10) nlines++;
      end
      $fclose(fd);
      fd = $fopen(TRACE, "r");
    end else begin
      $display("cannot open the trace file %s", TRACE);
      errors++;
    end
    limit = 64 * nlines + 1000;
    repeat (3) @(posedge bus);
    #2;
    rst_n = 1'b1;
    done = (fd == 0);
    while (!done) begin
      code = $fscanf(fd, " %c", cmd);
      if (code != 1) begin
        done = 1'b1;
      end else begin
        case (cmd)
          "/": skip_line(fd);    // column notes
          "#": begin
            end_test(name, base);
            code = $fscanf(fd, "%s", name);
            skip_line(fd);
            tests++;
            base = errors;
            repeat (8) @(posedge bus);  // let the stream drain
            #1;
            got_q.delete();
            irq_seen = 1'b0;
            swo_cnt  = 0;
            out_cnt  = 0;
            irq_cnt  = 0;
          end
          "W": begin
            code = $fscanf(fd, "%h %h", a, d);
            bus_access(1'b1, a, d, q);
          end
          "R": begin
            code = $fscanf(fd, "%h %h", a, d);
            bus_access(1'b0, a, 32'h0, q);
            check_value("rdata", d, q);
          end
          "E": begin
            code = $fscanf(fd, "%h", a);
            pulse_trigger(a[`LG_TN-1:0]);
          end
          "S": begin
            code = $fscanf(fd, "%d", n);
            collect_stream(fd, n);
          end
          "B": begin
            code = $fscanf(fd, "%h", a);
            bp_on = a[0];
          end
          "T": begin
            code = $fscanf(fd, "%d %d", n, m);
            check_value("trg_swo pulses", n, swo_cnt);
            check_value("trg_out pulses", m, out_cnt);
            check_value("irq_trg pulses", m, irq_cnt);  // fires with trg_out
          end
          "Q": wait_stop();
          default: begin
            $display("unknown trace command %c", cmd);
            errors++;
            skip_line(fd);
          end
        endcase
      end
    end
    end_test(name, base);
    if (fd != 0) $fclose(fd);
    $display("%0d tests, %0d checks, %0d errors", tests, checks, errors);
    if (errors == 0) begin
      $display("Verification passed");
    end else begin
      $display("Verification failed");
    end
    $finish;
  end

endmodule

`default_nettype wire

// ==== lg.f ====
+incdir+src
src/lg_pkg.sv
src/lg_regs.sv
src/lg_buf.sv
src/lg_asg.sv
src/lg_lin.sv
src/lg_top.sv
test/lg_tb.sv

// ==== Makefile ====
# Verilator build and run of the lg testbench

VERILATOR ?= verilator
TOP       ?= lg_tb
FLIST     ?= lg.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing --assert -Wno-fatal
PASS_MSG  ?= Verification passed

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  help   list the targets"
	@echo "  test   build with verilator and run the testbench"
	@echo "  clean  remove the build directory"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FLIST)
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; echo "$$out"; \
	echo "$$out" | grep -q "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)

// ==== test/lg_trace.txt ====
/ columns: W addr data | R addr expected | E mask | S count(dec) values | B on
/ T swo out (dec) | Q waits for irq_stp | # name starts a test; values in hex
# registers
R 38 00004000
R 00 00000008
R 08 00000000
W 04 000000ff
W 10 ffffffff
W 18 deadbeef
W 20 000000ff
W 24 0000ffff
W 2c 12345678
W 38 00012345
W 3c 0000ffff
R 04 0000000f
R 10 03ffffff
R 18 02adbeef
R 20 00000003
R 24 000003ff
R 2c 00005678
R 38 00002345
R 3c 00003fff
R 1c 00000000
# buffer
W 1000 00000100
W 1004 00000200
W 1008 00000300
W 100c 00000400
W 1010 00001fff
W 1014 00002000
W 1018 ffff3f00
W 101c 00000010
R 1004 00000200
R 1014 ffffe000
R 1018 ffffff00
# continuous
W 20 00000000
W 38 00004000
W 3c 00000000
W 10 00080000
W 14 00010000
W 18 00028000
W 00 00000002
S 12 0200 0400 3f00 0100 0400 2000 0100 0300 2000 0010 0300 1fff
T 1 1
R 00 00000004
W 00 00000001
R 00 00000008
# burst
W 14 00020000
W 18 00010000
W 20 00000001
W 24 00000003
W 28 00000002
W 2c 00000002
W 04 00000004
E 1
R 00 00000008
E 4
S 10 0300 0400 1fff 0000 0000 0300 0400 1fff 0000 0000
Q
T 0 1
R 00 00000008
R 30 00000002
R 34 00000002
# saturation
W 20 00000000
W 14 00040000
W 38 00006000
W 3c 00000800
W 00 00000002
S 8 1fff 2000 0680 0818 0980 0b00 0c80 0e00
W 00 00000001
# backpressure
B 1
W 38 00004000
W 3c 00000000
W 14 00010000
W 18 00028000
W 00 00000002
S 8 0200 0400 3f00 0100 0400 2000 0100 0300
W 00 00000002
S 4 2000 0010 0300 1fff
T 2 1
W 00 00000001
B 0
